// ==== src.f ====
+incdir+rtl
rtl/dkong_pkg.sv
rtl/dkong_bus_if.sv
rtl/dkong_addr_decode.sv
rtl/dkong_wait_nmi.sv
rtl/dkong_ctrl_latches.sv
rtl/dkong_adec.sv
tb/dkong_adec_checker.sv
tb/dkong_adec_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := dkong_adec_tb
RTL_TOP    := dkong_adec
FILELIST   := src.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
SIM_ARGS   := +verilator+error+limit+100
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb/dkong_adec_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module dkong_adec_tb
   import dkong_pkg::*;
();

   localparam int NUM_TESTS = 5;

   logic clk     = 1'b0;
   logic rst_n   = 1'b0;
   logic en_p    = 1'b0;   // Rising phase enable, the falling one is its inverse
   logic dkjr    = 1'b0;
   logic mreq_n  = 1'b1;
   logic rfsh_n  = 1'b1;
   logic rd_n    = 1'b1;
   logic wr_n    = 1'b1;
   logic vbusy_n = 1'b1;
   logic vblk_n  = 1'b1;
   cpu_addr_t ab = '0;
   cpu_nib_t  db = '0;
   logic wait_n, nmi_n;
   logic [14:0] sel_n;     // Selects in port order, ROM on top
   latch2_t q4h;
   latch8_t q5h, q6h, flip_m, snd_m;
   snd_cmd_t q3d;
   latch2_t bank_m;
   logic [31:0] lfsr = 32'h52a0_c7f0;   // Fixed seed
   logic [31:0] r;
   cpu_addr_t addr;        // Random map address
   int errors = 0;
   int checks = 0;
   int k;
   cpu_nib_t prev;         // Data nibble, later the sound command model

   dkong_adec dkong_adec_inst (
      .I_CLK24M(clk), .I_CLK_EN_P(en_p), .I_CLK_EN_N(~en_p), .I_RESET_n(rst_n),
      .I_DKJR(dkjr), .I_AB(ab), .I_DB(db), .I_MREQ_n(mreq_n), .I_RFSH_n(rfsh_n),
      .I_RD_n(rd_n), .I_WR_n(wr_n), .I_VRAMBUSY_n(vbusy_n), .I_VBLK_n(vblk_n),
      .O_WAIT_n(wait_n), .O_NMI_n(nmi_n),
      .O_ROM_CS_n(sel_n[14]), .O_RAM1_CS_n(sel_n[13]), .O_RAM2_CS_n(sel_n[12]),
      .O_RAM3_CS_n(sel_n[11]), .O_DMA_CS_n(sel_n[10]), .O_6A_G_n(sel_n[9]),
      .O_OBJ_RQ_n(sel_n[8]), .O_OBJ_RD_n(sel_n[7]), .O_OBJ_WR_n(sel_n[6]),
      .O_VRAM_RD_n(sel_n[5]), .O_VRAM_WR_n(sel_n[4]), .O_SW1_OE_n(sel_n[3]),
      .O_SW2_OE_n(sel_n[2]), .O_SW3_OE_n(sel_n[1]), .O_DIP_OE_n(sel_n[0]),
      .O_4H_Q(q4h), .O_5H_Q(q5h), .O_6H_Q(q6h), .O_3D_Q(q3d)
   );

   always #50 clk = ~clk;                        // 100 ns period
   always @(posedge clk) #5 en_p <= ~en_p;      // Enables alternate each cycle

   // Fibonacci LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("Error: %0t ns: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   // ====================
   // CPU bus cycles
   // ====================

   task automatic bus_cycle(input cpu_addr_t a, input cpu_nib_t d,
                            input logic m, input logic r_n, input logic w_n, input logic f_n);
      @(posedge clk);
      #5;
      ab     = a;
      db     = d;
      mreq_n = m;
      rd_n   = r_n;
      wr_n   = w_n;
      rfsh_n = f_n;
   endtask

   task automatic idle();   // Address and data left as they were
      bus_cycle(ab, db, 1'b1, 1'b1, 1'b1, 1'b1);
   endtask

   task automatic reset_dut();
      rst_n = 1'b0;
      repeat (3) @(posedge clk);
      #5 rst_n = 1'b1;
   endtask

   // Expected selects from the memory map, in sel_n order
   function automatic logic [14:0] map_model(input cpu_addr_t a, input logic rd, input logic wr,
                                            input logic rf, input logic jr);
      logic acc, obj, vid, io;
      acc = rd || wr;   // MREQ is low for every driven access
      obj = a >= 16'h7000 && a < 16'h7400;
      vid = a >= 16'h7400 && a < 16'h7800;
      io  = a[15:9] == 7'b0111_110;   // 7C00h-7DFFh
      return ~{(jr ? a < 16'h6000 : a < 16'h4000) && !rf,
               a >= 16'h6000 && a < 16'h6400 && acc, a >= 16'h6400 && a < 16'h6800 && acc,
               a >= 16'h6800 && a < 16'h6C00 && acc, a >= 16'h7800 && a < 16'h7C00,
               a >= 16'h7000 && a < 16'h7800, obj && (acc || rf), obj && rd, obj && wr,
               vid && rd, vid && wr, io && rd && a[8:7] == 2'd0, io && rd && a[8:7] == 2'd1,
               io && rd && a[8:7] == 2'd2, io && rd && a[8:7] == 2'd3};
   endfunction

   initial begin
      reset_dut();
      // Memory map, both boards
      for (k = 0; k < 160; k++) begin
         r    = rand_bits(4);
         prev = r[3:0];
         r    = rand_bits(19);
         addr = {1'b0, r[14:0]};
         if (r[16:15] == 2'd2) addr[14:12] = 3'b111;          // Object, video, DMA, I/O
         else if (r[16:15] == 2'd3) addr[14:10] = 5'b11111;   // I/O page only
         // Cycle kind in r[18:17]: read, write, refresh, read
         bus_cycle(addr, prev, 1'b0, r[18:17] == 2'd1 || r[18:17] == 2'd2,
                   r[18:17] != 2'd1, r[18:17] != 2'd2);
         dkjr = k >= 80;
         #40 check_eq("selects", sel_n, map_model(ab, !rd_n, !wr_n, !rfsh_n, dkjr));
      end
      idle();
      $display("Test memory map done, errors so far %0d", errors);
      reset_dut();   // Map writes may have touched the latches
      bank_m = '0;
      snd_m  = '0;
      flip_m = '0;
      for (k = 0; k < 48; k++) begin
         r = rand_bits(6);
         if (r[5:4] == 2'd0) bank_m[r[0]] = r[3];
         else if (r[5:4] == 2'd2) flip_m[r[2:0]] = r[3];
         else snd_m[r[2:0]] = r[3];
         bus_cycle((r[5:4] == 2'd0 ? 16'h7C80 : r[5:4] == 2'd2 ? 16'h7D80 : 16'h7D00)
                   | r[2:0], {3'b0, r[3]}, 1'b0, 1'b1, 1'b0, 1'b1);
         idle();
         #40;
         check_eq("O_4H_Q", q4h, bank_m);
         check_eq("O_6H_Q", q6h, snd_m);
         check_eq("O_5H_Q", q5h, flip_m);
      end
      $display("Test addressable latches done, errors so far %0d", errors);
      prev = '0;   // Cleared by the reset above
      for (k = 0; k < 8; k++) begin
         r = rand_bits(4);
         bus_cycle(16'h7C00, r[3:0], 1'b0, 1'b1, 1'b0, 1'b1);
         bus_cycle(16'h7C00, r[3:0], 1'b0, 1'b1, 1'b0, 1'b1);   // Strobe held over an edge
         #40 check_eq("O_3D_Q while strobe low", q3d, {1'b0, prev});
         idle();
         #40 check_eq("O_3D_Q at release", q3d, {1'b0, prev});
         idle();
         #40 check_eq("O_3D_Q after release", q3d, {1'b0, r[3:0]});
         prev = r[3:0];
      end
      $display("Test sound command done, errors so far %0d", errors);
      // NMI, mask is flip/mask bit 4
      bus_cycle(16'h7D84, 4'h1, 1'b0, 1'b1, 1'b0, 1'b1);
      idle();
      idle();
      vblk_n = 1'b0;
      for (k = 0; k < 8 && nmi_n; k++) @(posedge clk);
      check_eq("O_NMI_n on blank", nmi_n, 1'b0);
      @(posedge clk) #5 vblk_n = 1'b1;
      bus_cycle(16'h7D84, 4'h0, 1'b0, 1'b1, 1'b0, 1'b1);
      idle();
      for (k = 0; k < 8 && !nmi_n; k++) @(posedge clk);
      check_eq("O_NMI_n after mask clear", nmi_n, 1'b1);
      @(posedge clk) #5 vblk_n = 1'b0;
      repeat (4) begin
         @(posedge clk) #40 check_eq("O_NMI_n masked blank", nmi_n, 1'b1);
      end
      @(posedge clk);
      #5 vblk_n = 1'b1;
      $display("Test NMI done, errors so far %0d", errors);
      // Wait, hold a video RAM read until the write gate follows
      vbusy_n = 1'b0;
      bus_cycle(16'h7412, 4'h0, 1'b0, 1'b0, 1'b1, 1'b1);
      for (k = 0; k < 8 && wait_n; k++) @(posedge clk);
      check_eq("O_WAIT_n on busy", wait_n, 1'b0);
      repeat (2) @(posedge clk);
      bus_cycle(16'h7412, 4'h0, 1'b0, 1'b1, 1'b0, 1'b1);
      #40 check_eq("O_VRAM_WR_n during wait", sel_n[4], 1'b1);
      @(posedge clk);
      #5 vblk_n = 1'b0;   // Releases WAIT with no clock edge
      #1 check_eq("O_WAIT_n on blank", wait_n, 1'b1);
      idle();
      vbusy_n = 1'b1;
      vblk_n  = 1'b1;
      $display("Test wait done, errors so far %0d", errors);
      errors += dkong_adec_inst.chk_inst.fail_count;
      $display("Tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
      if (errors == 0) $display("RESULT: PASS");
      else $display("RESULT: FAIL");
      $finish;
   end

   // Watchdog, 20 us per test plus reset
   initial begin
      #(NUM_TESTS * 20_000 + 1_000);
      $display("Watchdog expired, the run timed out");
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb/dkong_adec_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module dkong_adec_checker (
   input logic I_CLK24M,
   input logic I_RESET_n,
   input logic I_VBLK_n,
   input logic O_WAIT_n,
   input logic O_NMI_n,
   input logic O_RAM1_CS_n,
   input logic O_RAM2_CS_n,
   input logic O_RAM3_CS_n,
   input logic O_OBJ_RQ_n,
   input logic vram_rq_n,
   input logic nmi_mask
);

   int fail_count = 0;   // Read by the testbench top

   // ====================
   // Bus selects
   // ====================

   // One memory device on the data bus at a time
   sel_onehot: assert property (@(posedge I_CLK24M) disable iff (!I_RESET_n)
      $onehot0(~{O_RAM1_CS_n, O_RAM2_CS_n, O_RAM3_CS_n, O_OBJ_RQ_n, vram_rq_n}))
      else begin
         $error("more than one RAM, object or video select low");
         fail_count++;
      end

   // ====================
   // Wait and NMI
   // ====================

   wait_blank: assert property (@(posedge I_CLK24M) disable iff (!I_RESET_n)
      !I_VBLK_n |-> O_WAIT_n)
      else begin
         $error("WAIT held low during blanking");
         fail_count++;
      end

   nmi_masked: assert property (@(posedge I_CLK24M) disable iff (!I_RESET_n)
      !nmi_mask |=> O_NMI_n)
      else begin
         $error("NMI low after the mask was cleared");
         fail_count++;
      end

endmodule

bind dkong_adec dkong_adec_checker chk_inst (.*);

`default_nettype wire

// ==== rtl/dkong_adec.sv ====
`timescale 1ns/100ps
`default_nettype none

module dkong_adec
   import dkong_pkg::*;
(
   input  logic      I_CLK24M,
   input  logic      I_CLK_EN_P,     // CPU clock phase enables
   input  logic      I_CLK_EN_N,
   input  logic      I_RESET_n,
   input  logic      I_DKJR,         // Junior ROM map
   input  cpu_addr_t I_AB,
   input  cpu_nib_t  I_DB,
   input  logic      I_MREQ_n,
   input  logic      I_RFSH_n,
   input  logic      I_RD_n,
   input  logic      I_WR_n,
   input  logic      I_VRAMBUSY_n,
   input  logic      I_VBLK_n,
   output logic      O_WAIT_n,
   output logic      O_NMI_n,
   output logic      O_ROM_CS_n,     // 0000h-3FFFh, or 5FFFh on Junior
   output logic      O_RAM1_CS_n,    // 6000h
   output logic      O_RAM2_CS_n,    // 6400h
   output logic      O_RAM3_CS_n,    // 6800h
   output logic      O_DMA_CS_n,     // 7800h
   output logic      O_6A_G_n,       // 7000h-77FFh
   output logic      O_OBJ_RQ_n,
   output logic      O_OBJ_RD_n,
   output logic      O_OBJ_WR_n,
   output logic      O_VRAM_RD_n,
   output logic      O_VRAM_WR_n,
   output logic      O_SW1_OE_n,     // 7C00h
   output logic      O_SW2_OE_n,     // 7C80h
   output logic      O_SW3_OE_n,     // 7D00h
   output logic      O_DIP_OE_n,     // 7D80h
   output latch2_t   O_4H_Q,
   output latch8_t   O_5H_Q,
   output latch8_t   O_6H_Q,
   output snd_cmd_t  O_3D_Q
);

   logic   wr_gate;
   logic   vram_rq_n;
   logic   nmi_mask;
   io_wr_t io_wr_n;

   // ====================
   // CPU bus
   // ====================

   dkong_bus_if bus_if ();

   assign bus_if.addr   = I_AB;
   assign bus_if.data   = I_DB;
   assign bus_if.mreq_n = I_MREQ_n;
   assign bus_if.rfsh_n = I_RFSH_n;
   assign bus_if.rd_n   = I_RD_n;
   assign bus_if.wr_n   = I_WR_n;

   // ====================
   // Blocks
   // ====================

   dkong_addr_decode u_decode (
      .bus       (bus_if.decode),
      .dkjr      (I_DKJR),
      .wr_gate   (wr_gate),
      .rom_cs_n  (O_ROM_CS_n),
      .ram1_cs_n (O_RAM1_CS_n),
      .ram2_cs_n (O_RAM2_CS_n),
      .ram3_cs_n (O_RAM3_CS_n),
      .dma_cs_n  (O_DMA_CS_n),
      .g6a_n     (O_6A_G_n),
      .obj_rq_n  (O_OBJ_RQ_n),
      .obj_rd_n  (O_OBJ_RD_n),
      .obj_wr_n  (O_OBJ_WR_n),
      .vram_rd_n (O_VRAM_RD_n),
      .vram_wr_n (O_VRAM_WR_n),
      .sw1_oe_n  (O_SW1_OE_n),
      .sw2_oe_n  (O_SW2_OE_n),
      .sw3_oe_n  (O_SW3_OE_n),
      .dip_oe_n  (O_DIP_OE_n),
      .vram_rq_n (vram_rq_n),
      .io_wr_n   (io_wr_n)
   );

   dkong_wait_nmi u_wait_nmi (
      .I_CLK24M    (I_CLK24M),
      .I_RESET_n   (I_RESET_n),
      .clk_en_p    (I_CLK_EN_P),
      .clk_en_n    (I_CLK_EN_N),
      .vram_busy_n (I_VRAMBUSY_n),
      .vblk_n      (I_VBLK_n),
      .vram_rq_n   (vram_rq_n),
      .nmi_mask    (nmi_mask),
      .wait_n      (O_WAIT_n),
      .wr_gate     (wr_gate),
      .nmi_n       (O_NMI_n)
   );

   dkong_ctrl_latches u_latches (
      .I_CLK24M  (I_CLK24M),
      .I_RESET_n (I_RESET_n),
      .bus       (bus_if.latch),
      .io_wr_n   (io_wr_n),
      .bank_q    (O_4H_Q),
      .flip_q    (O_5H_Q),
      .snd_q     (O_6H_Q),
      .snd_cmd   (O_3D_Q),
      .nmi_mask  (nmi_mask)
   );

endmodule

`default_nettype wire

// ==== rtl/dkong_ctrl_latches.sv ====
`timescale 1ns/100ps
`default_nettype none

module dkong_ctrl_latches
   import dkong_pkg::*;
(
   input  logic     I_CLK24M,
   input  logic     I_RESET_n,
   dkong_bus_if.latch bus,
   input  io_wr_t   io_wr_n,
   output latch2_t  bank_q,     // 4H, character bank and sound bit
   output latch8_t  flip_q,     // 5H, flip and NMI mask
   output latch8_t  snd_q,      // 6H, sound triggers
   output snd_cmd_t snd_cmd,    // 3D, sound command
   output logic     nmi_mask
);

   logic snd_wr_d;   // Strobe one clock late, for the release edge

   // Write one bit of an addressable latch
   function automatic latch8_t set_bit(
      input latch8_t    q,
      input logic [2:0] sel,
      input logic       d
   );
      latch8_t r;
      r      = q;
      r[sel] = d;
      return r;
   endfunction

   // ====================
   // Addressable latches
   // ====================

   // Each strobe writes data bit 0 to the bit named by the low address bits
   always_ff @(posedge I_CLK24M or negedge I_RESET_n) begin
      if (!I_RESET_n) begin
         bank_q <= '0;
         snd_q  <= '0;
         flip_q <= '0;
      end else begin
         if (!io_wr_n[1]) begin
            bank_q[bus.addr[0]] <= bus.data[0];   // 7C80h, 2 bits
         end
         if (!io_wr_n[2]) begin
            snd_q <= set_bit(snd_q, bus.addr[2:0], bus.data[0]);    // 7D00h
         end
         if (!io_wr_n[3]) begin
            flip_q <= set_bit(flip_q, bus.addr[2:0], bus.data[0]);  // 7D80h
         end
      end
   end

   assign nmi_mask = flip_q[4];

   // ====================
   // Sound command
   // ====================

   // Loads on the clock after the 7C00h strobe releases
   always_ff @(posedge I_CLK24M or negedge I_RESET_n) begin
      if (!I_RESET_n) begin
         snd_wr_d <= 1'b1;
         snd_cmd  <= '0;
      end else begin
         snd_wr_d <= io_wr_n[0];
         if (!snd_wr_d && io_wr_n[0]) begin
            snd_cmd <= {1'b0, bus.data};   // Fifth bit unused here
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/dkong_wait_nmi.sv ====
`timescale 1ns/100ps
`default_nettype none

module dkong_wait_nmi (
   input  logic I_CLK24M,
   input  logic I_RESET_n,
   input  logic clk_en_p,      // CPU clock rising phase
   input  logic clk_en_n,      // CPU clock falling phase
   input  logic vram_busy_n,   // Video side owns the RAM
   input  logic vblk_n,        // Vertical blank, active low
   input  logic vram_rq_n,
   input  logic nmi_mask,      // Flip/mask latch bit 4
   output logic wait_n,
   output logic wr_gate,
   output logic nmi_n
);

   logic wait_clr_n;   // Reset or blanking
   logic vblk_q;       // Previous vblank sample
   logic vblk_fall;

   // ====================
   // CPU wait
   // ====================

   // Blanking frees the RAM, so WAIT is dropped at once
   assign wait_clr_n = I_RESET_n & vblk_n;

   always_ff @(posedge I_CLK24M or negedge wait_clr_n) begin
      if (!wait_clr_n) begin
         wait_n <= 1'b1;
      end else if (clk_en_p) begin
         wait_n <= vram_busy_n | vram_rq_n;   // Stall only a video RAM access
      end
   end

   // Half a CPU cycle later, used to gate object and video writes
   always_ff @(negedge I_CLK24M or negedge I_RESET_n) begin
      if (!I_RESET_n) begin
         wr_gate <= 1'b1;
      end else if (clk_en_n) begin
         wr_gate <= wait_n;
      end
   end

   // ====================
   // Vblank NMI
   // ====================

   assign vblk_fall = vblk_q & ~vblk_n;

   always_ff @(posedge I_CLK24M or negedge I_RESET_n) begin
      if (!I_RESET_n) begin
         vblk_q <= 1'b1;
         nmi_n  <= 1'b1;
      end else begin
         vblk_q <= vblk_n;
         if (!nmi_mask) begin
            nmi_n <= 1'b1;          // Mask clears and holds off
         end else if (vblk_fall) begin
            nmi_n <= 1'b0;          // Start of blank
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/dkong_addr_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dkong_params.svh"

module dkong_addr_decode
   import dkong_pkg::*;
(
   dkong_bus_if.decode bus,
   input  logic   dkjr,        // Junior board, ROM extends to 5FFFh
   input  logic   wr_gate,     // Half-cycle wait copy, qualifies video writes
   output logic   rom_cs_n,
   output logic   ram1_cs_n,
   output logic   ram2_cs_n,
   output logic   ram3_cs_n,
   output logic   dma_cs_n,
   output logic   g6a_n,
   output logic   obj_rq_n,
   output logic   obj_rd_n,
   output logic   obj_wr_n,
   output logic   vram_rd_n,
   output logic   vram_wr_n,
   output logic   sw1_oe_n,
   output logic   sw2_oe_n,
   output logic   sw3_oe_n,
   output logic   dip_oe_n,
   output logic   vram_rq_n,   // Video RAM request, feeds the wait flop
   output io_wr_t io_wr_n
);

   // ====================
   // Region compares
   // ====================

   localparam cpu_addr_t rom_top_dk = 16'h4000;       // Plain board ROM ends at 3FFFh
   localparam cpu_addr_t ram_base   = `DK_RAM_BASE;
   localparam cpu_addr_t vid_base   = `DK_VID_BASE;
   localparam cpu_addr_t io_base    = `DK_IO_BASE;

   logic       rom_hit;
   logic       ram_page;      // 6000h-6FFFh
   logic       vid_page;      // 7000h-7FFFh
   logic       obj_hit;       // 7000h-73FFh
   logic       vram_hit;      // 7400h-77FFh
   logic       dma_hit;       // 7800h-7BFFh
   logic       io_hit;        // 7C00h-7FFFh
   logic       mem_rd;        // Qualified memory read
   logic       mem_wr;        // Qualified memory write
   logic [2:0] io_sel;        // 128-byte window within the I/O page

   assign rom_hit  = dkjr ? (bus.addr < ram_base) : (bus.addr < rom_top_dk);

   // 4K page compares on the top nibble
   assign ram_page = bus.addr[`DK_ADDR_W-1 -: 4] == ram_base[`DK_ADDR_W-1 -: 4];
   assign vid_page = bus.addr[`DK_ADDR_W-1 -: 4] == vid_base[`DK_ADDR_W-1 -: 4];

   // 1K slices of the video page
   assign obj_hit  = vid_page && (bus.addr[11:10] == 2'd0);
   assign vram_hit = vid_page && (bus.addr[11:10] == 2'd1);
   assign dma_hit  = vid_page && (bus.addr[11:10] == 2'd2);
   assign io_hit   = bus.addr[`DK_ADDR_W-1 -: 6] == io_base[`DK_ADDR_W-1 -: 6];

   assign mem_rd   = !bus.mreq_n && !bus.rd_n;
   assign mem_wr   = !bus.mreq_n && !bus.wr_n;
   assign io_sel   = bus.addr[9:7];

   // ====================
   // Memory selects
   // ====================

   // No MREQ qualifier on ROM, only refresh blanks it
   assign rom_cs_n  = !(rom_hit && bus.rfsh_n);

   // Work RAM, any read or write; the fourth 1K slot is unused
   assign ram1_cs_n = !(ram_page && bus.addr[11:10] == 2'd0 && (mem_rd || mem_wr));
   assign ram2_cs_n = !(ram_page && bus.addr[11:10] == 2'd1 && (mem_rd || mem_wr));
   assign ram3_cs_n = !(ram_page && bus.addr[11:10] == 2'd2 && (mem_rd || mem_wr));

   assign dma_cs_n  = !dma_hit;                      // Address only
   assign g6a_n     = !(vid_page && !bus.addr[11]);  // 7000h-77FFh, address only

   assign obj_rq_n  = !(obj_hit && !bus.mreq_n);
   assign vram_rq_n = !(vram_hit && !bus.mreq_n);

   assign obj_rd_n  = !(obj_hit && mem_rd);
   assign vram_rd_n = !(vram_hit && mem_rd);

   // Writes held off while the video side has the RAM
   assign obj_wr_n  = !(obj_hit && mem_wr && wr_gate);
   assign vram_wr_n = !(vram_hit && mem_wr && wr_gate);

   // ====================
   // I/O page
   // ====================

   assign sw1_oe_n = !(io_hit && mem_rd && io_sel == 3'd0);  // 7C00h
   assign sw2_oe_n = !(io_hit && mem_rd && io_sel == 3'd1);  // 7C80h
   assign sw3_oe_n = !(io_hit && mem_rd && io_sel == 3'd2);  // 7D00h
   assign dip_oe_n = !(io_hit && mem_rd && io_sel == 3'd3);  // 7D80h

   // Latch strobes share the read windows
   always_comb begin
      io_wr_n = '1;
      if (io_hit && mem_wr && !io_sel[2]) begin
         io_wr_n[io_sel[1:0]] = 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/dkong_bus_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Z80 bus as seen by the decoder and the latch block
interface dkong_bus_if
   import dkong_pkg::*;
();

   cpu_addr_t addr;     // Address bus
   cpu_nib_t  data;     // Data bits 3..0
   logic      mreq_n;   // Memory request
   logic      rfsh_n;   // Refresh cycle, ROM must stay quiet
   logic      rd_n;     // Read strobe
   logic      wr_n;     // Write strobe

   // Decoder looks at address and strobes only
   modport decode (
      input addr,
      input mreq_n,
      input rfsh_n,
      input rd_n,
      input wr_n
   );

   // Latches need the bit address and the data nibble
   modport latch (
      input addr,
      input data
   );

endinterface

`default_nettype wire

// ==== rtl/dkong_pkg.sv ====
`default_nettype none

`include "dkong_params.svh"

package dkong_pkg;

   // ====================
   // Bus types
   // ====================

   typedef logic [`DK_ADDR_W-1:0] cpu_addr_t;   // Full CPU address
   typedef logic [`DK_DATA_W-1:0] cpu_nib_t;    // Low data nibble

   // ====================
   // Latch types
   // ====================

   typedef logic [7:0] latch8_t;                // Flip/mask and sound latches
   typedef logic [1:0] latch2_t;                // Character bank and sound bit

   // Sound board takes 5 bits, top bit held at zero
   typedef logic [`DK_DATA_W:0] snd_cmd_t;

   // Active-low I/O write strobes
   //   [0] sound command 7C00h
   //   [1] bank latch    7C80h
   //   [2] sound latch   7D00h
   //   [3] flip/mask     7D80h
   typedef logic [3:0] io_wr_t;

endpackage

`default_nettype wire

// ==== rtl/dkong_params.svh ====
`ifndef DKONG_PARAMS_SVH
`define DKONG_PARAMS_SVH

// ====================
// Bus widths
// ====================

// Z80 address bus
`define DK_ADDR_W 16

// Only the low data nibble reaches the latches and the sound command
`define DK_DATA_W 4

// ====================
// Memory map bases
// ====================

// Work RAM, three 1K banks from here
`define DK_RAM_BASE 16'h6000

// Object RAM 7000h, video RAM 7400h, DMA 7800h
`define DK_VID_BASE 16'h7000

// Input ports and latch strobes, 128-byte windows
`define DK_IO_BASE 16'h7C00

`endif
